/* cool_mapper.f */
logic/cart_pkg.sv
logic/cart_regs.sv
logic/prg_map.sv
logic/chr_map.sv
logic/scanline_irq.sv
logic/bus_decode.sv
logic/cool_mapper.sv
tb/cool_mapper_properties.sv
tb/cool_mapper_tb.sv

/* tb/cool_mapper_tb.sv */
module cool_mapper_tb;
	import cart_pkg::*;

	localparam int CLK_PERIOD = 40;
	localparam int A12_FILTER = 3;
	localparam int IRQ_LATCH = 3; // Scanline count N
	localparam int TIMEOUT_CYCLES = 1000; // Full run is about 280 cycles

	logic m2;
	logic ppu_addr_in; // Active high reset
	logic romsel;
	logic cpu_rw;
	logic [14:0] cpu_addr;
	logic [7:0] cpu_data;
	logic ppu_rd;
	logic ppu_wr;
	logic [13:0] ppu_addr;
	logic [13:0] cpu_addr_out;
	logic flash_we;
	logic flash_oe;
	logic sram_ce;
	logic sram_we;
	logic sram_oe;
	logic [7:0] ppu_addr_out;
	logic ppu_rd_out;
	logic ppu_wr_out;
	logic ppu_ciram_a10;
	logic irq;
	int errors;
	int checks;
	logic [7:0] regs [8]; // MMC3 R0-R7 as written

	cool_mapper #(.A12_FILTER(A12_FILTER)) cool_mapper_i (.*);

	bind cool_mapper cool_mapper_properties properties_i (
		.m2(m2), .ppu_addr_in(ppu_addr_in), .romsel(romsel), .cpu_rw(cpu_rw),
		.cpu_addr(cpu_addr), .mapper(mapper), .flash_we(flash_we), .sram_ce(sram_ce), .irq(irq)
	);

	initial
	begin
		m2 = 1'b0;
		forever #(CLK_PERIOD / 2) m2 = ~m2;
	end

	// Base fills A26-A14, mask clears A18-A14, A13 passes
	function automatic int rom_addr_model(input int base, input int mask, input int bank);
		return (base << 1) | (bank & ~(mask << 1));
	endfunction

	function automatic int chr_addr_model(input int mask, input int mapped);
		return mapped & ~(mask << 3); // Mask covers A17-A13
	endfunction

	// PRG slot by A14:A13
	function automatic int mmc3_prg_slot(input logic mode, input int quarter);
		case (quarter)
			0: return mode ? 6'h3E : regs[6] & 8'h3F;
			1: return regs[7] & 8'h3F;
			2: return mode ? regs[6] & 8'h3F : 6'h3E;
			default: return 6'h3F; // Last bank
		endcase
	endfunction

	// CHR 1K slot by A12:A10
	function automatic int mmc3_chr_slot(input logic mode, input int slot);
		int half;
		int k;
		half = (slot >> 2) ^ mode; // 0 is the 2K pair half
		k = slot & 3;
		if (half == 0)
			return (regs[k >> 1] & 8'hFE) | (k & 1);
		return regs[2 + k];
	endfunction

	task automatic expect_equal(input string test, input int expected, input int actual);
		checks++;
		assert (expected == actual)
		else
		begin
			errors++;
			$display("CHECK FAILED %s: expected %0h, actual %0h", test, expected, actual);
		end
	endtask

	task automatic hold_reset();
		@(negedge m2);
		ppu_addr_in = 1'b1;
		repeat (3) @(negedge m2);
		ppu_addr_in = 1'b0;
	endtask

	task automatic cpu_write(input logic to_rom, input logic [14:0] addr, input logic [7:0] data);
		@(negedge m2);
		romsel = !to_rom;
		cpu_addr = addr;
		cpu_data = data;
		cpu_rw = 1'b0; // Taken at the next rising edge
		@(negedge m2);
		romsel = 1'b1;
		cpu_rw = 1'b1;
		cpu_addr = '0;
	endtask

	task automatic config_write(input cfg_reg_e idx, input logic [7:0] data);
		cpu_write(1'b0, 15'h5000 | 15'(idx), data);
	endtask

	task automatic cpu_read(input logic to_rom, input logic [14:0] addr);
		@(negedge m2);
		romsel = !to_rom;
		cpu_rw = 1'b1;
		cpu_addr = addr;
		#(CLK_PERIOD / 4); // Outputs settle
	endtask

	task automatic cpu_drive(input logic to_rom, input logic rw, input logic [14:0] addr);
		@(negedge m2);
		romsel = !to_rom;
		cpu_rw = rw;
		cpu_addr = addr;
		#(CLK_PERIOD / 4); // Strobes settle
	endtask

	task automatic ppu_read(input logic [13:0] addr);
		@(negedge m2);
		ppu_addr = addr;
		#(CLK_PERIOD / 4);
	endtask

	task automatic ppu_drive(input logic rd, input logic wr, input logic [13:0] addr);
		@(negedge m2);
		ppu_rd = rd;
		ppu_wr = wr;
		ppu_addr = addr;
		#(CLK_PERIOD / 4);
	endtask

	task automatic a12_pulse();
		@(negedge m2);
		ppu_addr = 14'h1000;
		@(negedge m2);
		ppu_addr = 14'h0000;
		repeat (4) @(negedge m2); // Long enough low time
	endtask

	task automatic a12_glitches(input int count);
		repeat (count)
		begin
			@(negedge m2);
			ppu_addr = 14'h1000;
			@(negedge m2);
			ppu_addr = 14'h0000;
			repeat (A12_FILTER - 2) @(negedge m2); // Too short to arm
		end
		repeat (A12_FILTER + 1) @(negedge m2);
	endtask

	task automatic reset_defaults();
		hold_reset();
		expect_equal("reset irq", 0, irq);
		expect_equal("reset flash_we", 1, flash_we);
		expect_equal("reset sram_ce", 1, sram_ce);
		cpu_read(1'b1, 15'h4000);
		expect_equal("reset nrom $C000", rom_addr_model(0, 0, 6'h3E), cpu_addr_out);
		ppu_read(14'h2400);
		expect_equal("reset ciram a10 high", 1, ppu_ciram_a10);
		ppu_read(14'h2800);
		expect_equal("reset ciram a10 low", 0, ppu_ciram_a10);
	endtask

	task automatic outer_registers();
		hold_reset();
		config_write(CFG_BASE_HI, 8'h03);
		config_write(CFG_BASE_LO, 8'h40);
		config_write(CFG_PRG_MASK, 8'h1C);
		cpu_read(1'b1, 15'h4000);
		expect_equal("outer base and mask", rom_addr_model(13'h0340, 5'h1C, 6'h3E), cpu_addr_out);
		config_write(CFG_CHR_BANK, 8'h1F);
		config_write(CFG_CHR_MASK, 8'h05);
		ppu_read(14'h0C00); // Slot 3 of the bank
		expect_equal("outer chr mask", chr_addr_model(5'h05, 8'hFB), ppu_addr_out);
		config_write(CFG_SRAM_PAGE, 8'h02);
		cpu_read(1'b0, 15'h6000);
		expect_equal("outer sram disabled", 1, sram_ce);
		config_write(CFG_CONTROL, 8'h01); // SRAM enable
		cpu_read(1'b0, 15'h6000);
		expect_equal("outer sram_ce", 0, sram_ce);
		expect_equal("outer sram page", 2, cpu_addr_out);
		config_write(CFG_CONTROL, 8'h81); // Lockout
		config_write(CFG_BASE_LO, 8'hFF);
		config_write(CFG_CONTROL, 8'h00);
		cpu_read(1'b0, 15'h6000);
		expect_equal("lockout sram_ce", 0, sram_ce);
		cpu_read(1'b1, 15'h4000);
		expect_equal("lockout base", rom_addr_model(13'h0340, 5'h1C, 6'h3E), cpu_addr_out);
	endtask

	task automatic strobe_outputs();
		hold_reset();
		config_write(CFG_CONTROL, 8'h06); // PRG and CHR writes enabled
		cpu_drive(1'b1, 1'b0, 15'h0000);
		expect_equal("flash write flash_we", 0, flash_we);
		expect_equal("flash write flash_oe", 1, flash_oe);
		expect_equal("flash write sram_we", 0, sram_we);
		expect_equal("flash write sram_oe", 1, sram_oe);
		cpu_drive(1'b1, 1'b1, 15'h0000);
		expect_equal("flash read flash_we", 1, flash_we);
		expect_equal("flash read flash_oe", 0, flash_oe);
		expect_equal("flash read sram_we", 1, sram_we);
		expect_equal("flash read sram_oe", 0, sram_oe);
		cpu_drive(1'b0, 1'b1, 15'h6000);
		expect_equal("sram read flash_oe", 1, flash_oe);
		ppu_drive(1'b0, 1'b1, 14'h0000);
		expect_equal("chr read ppu_rd_out", 0, ppu_rd_out);
		expect_equal("chr read ppu_wr_out", 1, ppu_wr_out);
		ppu_drive(1'b0, 1'b1, 14'h2000); // Nametable stays on CIRAM
		expect_equal("nametable read ppu_rd_out", 1, ppu_rd_out);
		ppu_drive(1'b1, 1'b0, 14'h0000);
		expect_equal("chr write ppu_wr_out", 0, ppu_wr_out);
		expect_equal("chr write ppu_rd_out", 1, ppu_rd_out);
		ppu_drive(1'b1, 1'b0, 14'h2000);
		expect_equal("nametable write ppu_wr_out", 1, ppu_wr_out);
		config_write(CFG_CONTROL, 8'h00); // Writes disabled
		ppu_drive(1'b1, 1'b0, 14'h0000);
		expect_equal("chr write disabled ppu_wr_out", 1, ppu_wr_out);
		cpu_drive(1'b1, 1'b0, 15'h0000);
		expect_equal("flash write disabled flash_we", 1, flash_we);
		cpu_drive(1'b1, 1'b1, 15'h0000); // Back to a read cycle
		ppu_drive(1'b1, 1'b1, 14'h0000);
	endtask

	task automatic simple_mappers();
		int bank;
		hold_reset();
		config_write(CFG_MAPPER, MAP_UXROM);
		bank = $urandom & 32'h1F;
		cpu_write(1'b1, 15'h0000, 8'(bank));
		cpu_read(1'b1, 15'h0000);
		expect_equal("uxrom $8000", rom_addr_model(0, 0, bank << 1), cpu_addr_out);
		cpu_read(1'b1, 15'h2000);
		expect_equal("uxrom $A000", rom_addr_model(0, 0, (bank << 1) | 1), cpu_addr_out);
		cpu_read(1'b1, 15'h4000);
		expect_equal("uxrom $C000", rom_addr_model(0, 0, 6'h3E), cpu_addr_out);
		config_write(CFG_MAPPER, MAP_CNROM);
		cpu_write(1'b1, 15'h0000, 8'h0B);
		ppu_read(14'h1400); // A12:A10 = 5
		expect_equal("cnrom chr", chr_addr_model(0, (8'h0B << 3) | 5), ppu_addr_out);
		config_write(CFG_MAPPER, MAP_AXROM);
		cpu_write(1'b1, 15'h0000, 8'h13); // Bank 3, screen B
		cpu_read(1'b1, 15'h0000);
		expect_equal("axrom $8000", rom_addr_model(0, 0, 3 << 2), cpu_addr_out);
		cpu_read(1'b1, 15'h6000);
		expect_equal("axrom $E000", rom_addr_model(0, 0, (3 << 2) | 3), cpu_addr_out);
		ppu_read(14'h2000); // A11 and A10 low
		expect_equal("axrom single b", 1, ppu_ciram_a10);
		cpu_write(1'b1, 15'h0000, 8'h05); // Bank 5, screen A
		cpu_read(1'b1, 15'h4000);
		expect_equal("axrom $C000", rom_addr_model(0, 0, (5 << 2) | 2), cpu_addr_out);
		ppu_read(14'h2C00); // A11 and A10 high
		expect_equal("axrom single a", 0, ppu_ciram_a10);
	endtask

	task automatic mmc3_banking();
		hold_reset();
		config_write(CFG_MAPPER, MAP_MMC3);
		for (int r = 0; r < 8; r++)
		begin
			regs[r] = 8'($urandom);
			cpu_write(1'b1, 15'h0000, 8'(r)); // Bank select
			cpu_write(1'b1, 15'h0001, regs[r]); // Bank data
		end
		for (int mode = 0; mode < 2; mode++)
		begin
			cpu_write(1'b1, 15'h0000, {mode[0], mode[0], 6'd0}); // CHR and PRG mode
			for (int q = 0; q < 4; q++)
			begin
				cpu_read(1'b1, 15'(q << 13));
				expect_equal($sformatf("mmc3 prg mode %0d slot %0d", mode, q),
					rom_addr_model(0, 0, mmc3_prg_slot(mode[0], q)), cpu_addr_out);
			end
			for (int s = 0; s < 8; s++)
			begin
				ppu_read(14'(s << 10));
				expect_equal($sformatf("mmc3 chr mode %0d slot %0d", mode, s),
					mmc3_chr_slot(mode[0], s), ppu_addr_out);
			end
		end
		cpu_write(1'b1, 15'h2000, 8'h01); // Horizontal
		ppu_read(14'h2800);
		expect_equal("mmc3 horizontal", 1, ppu_ciram_a10);
		cpu_write(1'b1, 15'h2000, 8'h00); // Vertical
		ppu_read(14'h2800);
		expect_equal("mmc3 vertical", 0, ppu_ciram_a10);
	endtask

	task automatic mmc3_scanline_irq();
		hold_reset();
		config_write(CFG_MAPPER, MAP_MMC3);
		cpu_write(1'b1, 15'h4000, 8'(IRQ_LATCH));
		cpu_write(1'b1, 15'h4001, 8'h00); // Reload
		cpu_write(1'b1, 15'h6001, 8'h00); // Enable
		for (int i = 1; i <= IRQ_LATCH + 1; i++)
		begin
			a12_pulse();
			expect_equal($sformatf("irq after rise %0d", i), (i == IRQ_LATCH + 1), irq);
		end
		cpu_write(1'b1, 15'h6000, 8'h00); // Disable acks
		expect_equal("irq after disable", 0, irq);
		cpu_write(1'b1, 15'h6001, 8'h00);
		repeat (IRQ_LATCH - 1) a12_pulse(); // Counter reloads, then down to 2
		expect_equal("irq before glitches", 0, irq);
		a12_glitches(3); // Only the first rise counts
		expect_equal("irq after glitches", 0, irq);
		a12_pulse(); // Counter reaches 0
		expect_equal("irq after filtered rise", 1, irq);
	endtask

	initial
	begin
		#(TIMEOUT_CYCLES * CLK_PERIOD);
		$display("Timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("Some tests failed");
		$finish;
	end

	initial
	begin
		void'($urandom(32'h8ca2c1a1));
		errors = 0;
		checks = 0;
		ppu_addr_in = 1'b1;
		romsel = 1'b1;
		cpu_rw = 1'b1;
		cpu_addr = '0;
		cpu_data = '0;
		ppu_rd = 1'b1;
		ppu_wr = 1'b1;
		ppu_addr = '0;
		reset_defaults();
		outer_registers();
		strobe_outputs();
		simple_mappers();
		mmc3_banking();
		mmc3_scanline_irq();
		$display("%0d checks, %0d check errors, %0d assertion errors", checks, errors,
			cool_mapper_i.properties_i.prop_errors);
		if (errors == 0 && cool_mapper_i.properties_i.prop_errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

/* tb/cool_mapper_properties.sv */
module cool_mapper_properties (
	input logic m2,
	input logic ppu_addr_in,
	input logic romsel,
	input logic cpu_rw,
	input logic [14:0] cpu_addr,
	input cart_pkg::mapper_e mapper,
	input logic flash_we,
	input logic sram_ce,
	input logic irq
);
	import cart_pkg::*;

	int prop_errors = 0; // Failed assertion count
	logic disable_write; // MMC3 $E000 write

	assign disable_write = !cpu_rw && !romsel && (mapper == MAP_MMC3) &&
		(cpu_addr[14:13] == 2'b11) && !cpu_addr[0];

	// Flash never written during a read cycle
	flash_we_idle: assert property (@(posedge m2) disable iff (ppu_addr_in) cpu_rw |-> flash_we)
	else
	begin
		prop_errors++;
		$error("flash_we was active while cpu_rw was high");
	end

	sram_ce_rom: assert property (@(posedge m2) disable iff (ppu_addr_in) !romsel |-> sram_ce)
	else
	begin
		prop_errors++;
		$error("sram_ce was active during a ROM access");
	end

	irq_ack: assert property (@(posedge m2) disable iff (ppu_addr_in) disable_write |=> !irq)
	else
	begin
		prop_errors++;
		$error("irq stayed high after an MMC3 IRQ disable write");
	end

endmodule

/* logic/cool_mapper.sv */
module cool_mapper #(
	parameter int A12_FILTER = 3
) (
	input logic m2,
	input logic ppu_addr_in,
	input logic romsel,
	input logic cpu_rw,
	input logic [14:0] cpu_addr,
	input logic [7:0] cpu_data,
	input logic ppu_rd,
	input logic ppu_wr,
	input logic [13:0] ppu_addr,
	output logic [13:0] cpu_addr_out,
	output logic flash_we,
	output logic flash_oe,
	output logic sram_ce,
	output logic sram_we,
	output logic sram_oe,
	output logic [7:0] ppu_addr_out,
	output logic ppu_rd_out,
	output logic ppu_wr_out,
	output logic ppu_ciram_a10,
	output logic irq
);
	import cart_pkg::*;

	logic [PRG_BASE_W-1:0] cpu_base;
	logic [MASK_W-1:0] prg_mask;
	logic [MASK_W-1:0] chr_mask;
	logic [1:0] sram_page;
	logic sram_enabled;
	logic prg_write_enabled;
	logic chr_write_enabled;
	mirror_e mirroring;
	mapper_e mapper;
	logic [PRG_BANK_W-1:0] prg_bank;
	logic [CHR_BANK_W-1:0] chr_bank;
	logic [7:0] mmc3_bank [8]; // R0-R7
	logic mmc3_prg_mode;
	logic mmc3_chr_mode;
	logic [7:0] irq_latch;
	logic irq_reload_req;
	logic irq_enable;
	logic [PRG_BANK_W-1:0] prg_mapped;
	logic [CHR_BANK_W-1:0] chr_mapped;

	cart_regs cart_regs_i (
		.m2(m2), .ppu_addr_in(ppu_addr_in), .romsel(romsel), .cpu_rw(cpu_rw),
		.cpu_addr(cpu_addr), .cpu_data(cpu_data), .cpu_base(cpu_base), .prg_mask(prg_mask),
		.chr_mask(chr_mask), .sram_page(sram_page), .sram_enabled(sram_enabled),
		.prg_write_enabled(prg_write_enabled), .chr_write_enabled(chr_write_enabled),
		.mirroring(mirroring), .mapper(mapper), .prg_bank(prg_bank), .chr_bank(chr_bank),
		.mmc3_bank(mmc3_bank), .mmc3_prg_mode(mmc3_prg_mode), .mmc3_chr_mode(mmc3_chr_mode),
		.irq_latch(irq_latch), .irq_reload_req(irq_reload_req), .irq_enable(irq_enable)
	);

	prg_map prg_map_i (
		.cpu_addr(cpu_addr), .mapper(mapper), .prg_bank(prg_bank), .mmc3_bank(mmc3_bank),
		.mmc3_prg_mode(mmc3_prg_mode), .prg_mapped(prg_mapped)
	);

	chr_map chr_map_i (
		.ppu_addr(ppu_addr), .mapper(mapper), .chr_bank(chr_bank), .mmc3_bank(mmc3_bank),
		.mmc3_chr_mode(mmc3_chr_mode), .chr_mapped(chr_mapped)
	);

	scanline_irq #(.A12_FILTER(A12_FILTER)) scanline_irq_i (
		.m2(m2), .ppu_addr_in(ppu_addr_in), .ppu_a12(ppu_addr[12]), .irq_latch(irq_latch),
		.irq_reload_req(irq_reload_req), .irq_enable(irq_enable), .irq(irq)
	);

	bus_decode bus_decode_i (
		.romsel(romsel), .cpu_rw(cpu_rw), .cpu_addr(cpu_addr), .ppu_rd(ppu_rd), .ppu_wr(ppu_wr),
		.ppu_addr(ppu_addr), .prg_mapped(prg_mapped), .chr_mapped(chr_mapped),
		.cpu_base(cpu_base), .prg_mask(prg_mask), .chr_mask(chr_mask), .sram_page(sram_page),
		.sram_enabled(sram_enabled), .prg_write_enabled(prg_write_enabled),
		.chr_write_enabled(chr_write_enabled), .mirroring(mirroring),
		.cpu_addr_out(cpu_addr_out), .flash_we(flash_we), .flash_oe(flash_oe),
		.sram_ce(sram_ce), .sram_we(sram_we), .sram_oe(sram_oe), .ppu_addr_out(ppu_addr_out),
		.ppu_rd_out(ppu_rd_out), .ppu_wr_out(ppu_wr_out), .ppu_ciram_a10(ppu_ciram_a10)
	);

endmodule

/* logic/bus_decode.sv */
module bus_decode (
	input logic romsel,
	input logic cpu_rw,
	input logic [14:0] cpu_addr,
	input logic ppu_rd,
	input logic ppu_wr,
	input logic [13:0] ppu_addr,
	input logic [cart_pkg::PRG_BANK_W-1:0] prg_mapped,
	input logic [cart_pkg::CHR_BANK_W-1:0] chr_mapped,
	input logic [cart_pkg::PRG_BASE_W-1:0] cpu_base,
	input logic [cart_pkg::MASK_W-1:0] prg_mask,
	input logic [cart_pkg::MASK_W-1:0] chr_mask,
	input logic [1:0] sram_page,
	input logic sram_enabled,
	input logic prg_write_enabled,
	input logic chr_write_enabled,
	input cart_pkg::mirror_e mirroring,
	output logic [cart_pkg::PRG_BASE_W:0] cpu_addr_out,
	output logic flash_we,
	output logic flash_oe,
	output logic sram_ce,
	output logic sram_we,
	output logic sram_oe,
	output logic [cart_pkg::CHR_BANK_W-1:0] ppu_addr_out,
	output logic ppu_rd_out,
	output logic ppu_wr_out,
	output logic ppu_ciram_a10
);
	import cart_pkg::*;

	logic [PRG_BASE_W-1:0] prg_high; // A26-A14 of a ROM access

	assign prg_high = cpu_base | {{(PRG_BASE_W-MASK_W){1'b0}}, prg_mapped[PRG_BANK_W-1:1] & ~prg_mask};
	assign cpu_addr_out = !romsel ? {prg_high, prg_mapped[0]} : {{(PRG_BASE_W-1){1'b0}}, sram_page};
	assign ppu_addr_out = {chr_mapped[CHR_BANK_W-1:3] & ~chr_mask, chr_mapped[2:0]}; // Mask A17-A13

	// All strobes active low
	assign flash_we = cpu_rw | romsel | ~prg_write_enabled;
	assign flash_oe = ~cpu_rw | romsel;
	assign sram_ce = ~(cpu_addr[14] & cpu_addr[13] & romsel & sram_enabled); // $6000-$7FFF
	assign sram_we = cpu_rw;
	assign sram_oe = ~cpu_rw;
	assign ppu_rd_out = ppu_rd | ppu_addr[13]; // Nametables stay on CIRAM
	assign ppu_wr_out = ppu_wr | ppu_addr[13] | ~chr_write_enabled;

	always_comb
	begin
		case (mirroring)
			MIR_VERTICAL: ppu_ciram_a10 = ppu_addr[10];
			MIR_HORIZONTAL: ppu_ciram_a10 = ppu_addr[11];
			MIR_SINGLE_A: ppu_ciram_a10 = 1'b0;
			default: ppu_ciram_a10 = 1'b1; // Single B
		endcase
	end

endmodule

/* logic/scanline_irq.sv */
module scanline_irq #(
	parameter int A12_FILTER = 3
) (
	input logic m2,
	input logic ppu_addr_in,
	input logic ppu_a12,
	input logic [7:0] irq_latch,
	input logic irq_reload_req,
	input logic irq_enable,
	output logic irq
);
	localparam int LOW_W = $clog2(A12_FILTER + 2); // Holds 0..A12_FILTER

	logic [LOW_W-1:0] low_cnt; // Consecutive low samples, saturating
	logic a12_prev;
	logic reload_pend; // Reload waits for the next A12 event
	logic [7:0] counter;
	logic irq_flag;
	logic a12_event;
	logic reload_now;
	logic [7:0] counter_next;

	// Rising A12 after a long enough low period
	assign a12_event = ppu_a12 && !a12_prev && (low_cnt >= LOW_W'(A12_FILTER));
	assign reload_now = reload_pend || irq_reload_req; // Request arriving on the event edge counts
	assign counter_next = (reload_now || counter == 8'd0) ? irq_latch : counter - 8'd1;
	assign irq = irq_flag && irq_enable; // Drops with the disable write

	always_ff @(posedge m2 or posedge ppu_addr_in)
	begin
		if (ppu_addr_in)
		begin
			low_cnt <= '0;
			a12_prev <= 1'b0;
			reload_pend <= 1'b0;
			counter <= '0;
			irq_flag <= 1'b0;
		end
		else
		begin
			a12_prev <= ppu_a12;
			if (ppu_a12)
				low_cnt <= '0;
			else if (low_cnt < LOW_W'(A12_FILTER))
				low_cnt <= low_cnt + 1'b1;
			if (a12_event)
			begin
				counter <= counter_next;
				reload_pend <= 1'b0; // Consumed by this event
			end
			else if (irq_reload_req)
				reload_pend <= 1'b1;
			if (!irq_enable)
				irq_flag <= 1'b0; // Ack
			else if (a12_event && counter_next == 8'd0)
				irq_flag <= 1'b1;
		end
	end

endmodule

/* logic/chr_map.sv */
module chr_map (
	input logic [13:0] ppu_addr,
	input cart_pkg::mapper_e mapper,
	input logic [cart_pkg::CHR_BANK_W-1:0] chr_bank,
	input logic [7:0] mmc3_bank [8],
	input logic mmc3_chr_mode,
	output logic [cart_pkg::CHR_BANK_W-1:0] chr_mapped
);
	import cart_pkg::*;

	always_comb
	begin
		if (mapper == MAP_MMC3)
		begin
			if (ppu_addr[12] == mmc3_chr_mode)
			begin
				// 2K half, low bit of R0/R1 dropped
				if (ppu_addr[11])
					chr_mapped = {mmc3_bank[1][CHR_BANK_W-1:1], ppu_addr[10]};
				else
					chr_mapped = {mmc3_bank[0][CHR_BANK_W-1:1], ppu_addr[10]};
			end
			else
			begin
				case (ppu_addr[11:10]) // 1K slots R2-R5
					2'd0: chr_mapped = mmc3_bank[2];
					2'd1: chr_mapped = mmc3_bank[3];
					2'd2: chr_mapped = mmc3_bank[4];
					default: chr_mapped = mmc3_bank[5];
				endcase
			end
		end
		else
		begin
			chr_mapped = {chr_bank[4:0], ppu_addr[12:10]}; // Plain 8K bank
		end
	end

endmodule

/* logic/prg_map.sv */
module prg_map (
	input logic [14:0] cpu_addr,
	input cart_pkg::mapper_e mapper,
	input logic [cart_pkg::PRG_BANK_W-1:0] prg_bank,
	input logic [7:0] mmc3_bank [8],
	input logic mmc3_prg_mode,
	output logic [cart_pkg::PRG_BANK_W-1:0] prg_mapped
);
	import cart_pkg::*;

	localparam logic [PRG_BANK_W-1:0] LAST_8K = '1; // Bank at $E000
	localparam logic [PRG_BANK_W-1:0] SECOND_LAST_8K = {{(PRG_BANK_W-1){1'b1}}, 1'b0};

	always_comb
	begin
		case (mapper)
			MAP_AXROM:
				// 32K window, A14 and A13 pass through
				prg_mapped = {prg_bank[PRG_BANK_W-3:0], cpu_addr[14:13]};
			MAP_MMC3:
			begin
				case ({cpu_addr[14:13], mmc3_prg_mode})
					3'b000, 3'b101: prg_mapped = mmc3_bank[6][PRG_BANK_W-1:0]; // R6
					3'b001, 3'b100: prg_mapped = SECOND_LAST_8K; // Fixed slot swapped by mode
					3'b010, 3'b011: prg_mapped = mmc3_bank[7][PRG_BANK_W-1:0]; // R7 at $A000
					default: prg_mapped = LAST_8K; // $E000 never moves
				endcase
			end
			default:
			begin
				// NROM, UxROM and CNROM share the 16K layout
				if (cpu_addr[14])
					prg_mapped = {{(PRG_BANK_W-1){1'b1}}, cpu_addr[13]}; // Last 16K at $C000
				else
					prg_mapped = {prg_bank[PRG_BANK_W-2:0], cpu_addr[13]}; // Switchable at $8000
			end
		endcase
	end

endmodule

/* logic/cart_regs.sv */
module cart_regs (
	input logic m2,
	input logic ppu_addr_in,
	input logic romsel,
	input logic cpu_rw,
	input logic [14:0] cpu_addr,
	input logic [7:0] cpu_data,
	output logic [cart_pkg::PRG_BASE_W-1:0] cpu_base,
	output logic [cart_pkg::MASK_W-1:0] prg_mask,
	output logic [cart_pkg::MASK_W-1:0] chr_mask,
	output logic [1:0] sram_page,
	output logic sram_enabled,
	output logic prg_write_enabled,
	output logic chr_write_enabled,
	output cart_pkg::mirror_e mirroring,
	output cart_pkg::mapper_e mapper,
	output logic [cart_pkg::PRG_BANK_W-1:0] prg_bank,
	output logic [cart_pkg::CHR_BANK_W-1:0] chr_bank,
	output logic [7:0] mmc3_bank [8],
	output logic mmc3_prg_mode,
	output logic mmc3_chr_mode,
	output logic [7:0] irq_latch,
	output logic irq_reload_req,
	output logic irq_enable
);
	import cart_pkg::*;

	// MMC3 register port, {A14, A13, A0}
	typedef enum logic [2:0]
	{
		MMC3_SELECT = 3'b000, // $8000 even
		MMC3_DATA = 3'b001, // $8001 odd
		MMC3_MIRROR = 3'b010, // $A000 even
		MMC3_PROTECT = 3'b011, // $A001 odd
		MMC3_LATCH = 3'b100, // $C000 even
		MMC3_RELOAD = 3'b101, // $C001 odd
		MMC3_DISABLE = 3'b110, // $E000 even
		MMC3_ENABLE = 3'b111 // $E001 odd
	} mmc3_cmd_e;

	logic lockout; // Freezes $5xxx until reset
	logic [2:0] mmc3_sel; // Target of the next bank data write
	logic cfg_write;
	logic rom_write;
	cfg_reg_e cfg_reg;
	mmc3_cmd_e mmc3_cmd;

	assign cfg_write = !cpu_rw && romsel && (cpu_addr[14:12] == 3'b101) && !lockout; // $5000-$5FFF
	assign rom_write = !cpu_rw && !romsel; // $8000-$FFFF
	assign cfg_reg = cfg_reg_e'(cpu_addr[2:0]);
	assign mmc3_cmd = mmc3_cmd_e'({cpu_addr[14:13], cpu_addr[0]});

	always_ff @(posedge m2 or posedge ppu_addr_in)
	begin
		if (ppu_addr_in)
		begin
			cpu_base <= '0;
			prg_mask <= '0;
			chr_mask <= '0;
			sram_page <= '0;
			sram_enabled <= 1'b0;
			prg_write_enabled <= 1'b0;
			chr_write_enabled <= 1'b0;
			mirroring <= MIR_VERTICAL;
			mapper <= MAP_NROM;
			lockout <= 1'b0;
			prg_bank <= '0;
			chr_bank <= '0;
			for (int i = 0; i < 8; i++)
				mmc3_bank[i] <= '0;
			mmc3_sel <= '0;
			mmc3_prg_mode <= 1'b0;
			mmc3_chr_mode <= 1'b0;
			irq_latch <= '0;
			irq_reload_req <= 1'b0;
			irq_enable <= 1'b0;
		end
		else
		begin
			irq_reload_req <= 1'b0; // Pulse lasts one cycle
			if (cfg_write)
			begin
				case (cfg_reg)
					CFG_BASE_HI: cpu_base[PRG_BASE_W-1:8] <= cpu_data[4:0]; // A26-A22
					CFG_BASE_LO: cpu_base[7:0] <= cpu_data; // A21-A14
					CFG_PRG_MASK: prg_mask <= cpu_data[MASK_W-1:0];
					CFG_CHR_BANK: chr_bank <= cpu_data;
					CFG_CHR_MASK: chr_mask <= cpu_data[MASK_W-1:0];
					CFG_SRAM_PAGE: {prg_bank, sram_page} <= cpu_data;
					CFG_MAPPER: mapper <= mapper_e'(cpu_data[4:0]); // Top bits ignored
					CFG_CONTROL:
					begin
						lockout <= cpu_data[7];
						mirroring <= mirror_e'(cpu_data[4:3]);
						prg_write_enabled <= cpu_data[2];
						chr_write_enabled <= cpu_data[1];
						sram_enabled <= cpu_data[0];
					end
					default: ;
				endcase
			end
			if (rom_write)
			begin
				case (mapper)
					MAP_UXROM: prg_bank <= cpu_data[PRG_BANK_W-1:0]; // 16K bank at $8000
					MAP_CNROM: chr_bank <= cpu_data; // 8K CHR bank
					MAP_AXROM:
					begin
						prg_bank <= {1'b0, cpu_data[4:0]}; // 32K bank
						mirroring <= cpu_data[4] ? MIR_SINGLE_B : MIR_SINGLE_A;
					end
					MAP_MMC3:
					begin
						case (mmc3_cmd)
							MMC3_SELECT:
							begin
								mmc3_sel <= cpu_data[2:0];
								mmc3_prg_mode <= cpu_data[6];
								mmc3_chr_mode <= cpu_data[7];
							end
							MMC3_DATA: mmc3_bank[mmc3_sel] <= cpu_data; // R0-R7
							MMC3_MIRROR: mirroring <= cpu_data[0] ? MIR_HORIZONTAL : MIR_VERTICAL;
							MMC3_PROTECT: ; // WRAM protect not kept
							MMC3_LATCH: irq_latch <= cpu_data;
							MMC3_RELOAD: irq_reload_req <= 1'b1;
							MMC3_DISABLE: irq_enable <= 1'b0; // Also acks the IRQ
							MMC3_ENABLE: irq_enable <= 1'b1;
							default: ;
						endcase
					end
					default: ; // NROM has no inner registers
				endcase
			end
		end
	end

endmodule

/* logic/cart_pkg.sv */
package cart_pkg;

	// Widths of the banking fields
	localparam int PRG_BASE_W = 13; // Base covers A26-A14
	localparam int PRG_BANK_W = 6; // Mapped A18-A13
	localparam int CHR_BANK_W = 8; // Mapped A17-A10
	localparam int MASK_W = 5; // PRG mask A18-A14, CHR mask A17-A13

	// Inner mapper codes, as written to $5xx6
	typedef enum logic [4:0]
	{
		MAP_NROM = 5'd0, // Mapper #0
		MAP_UXROM = 5'd1, // Mapper #2
		MAP_CNROM = 5'd2, // Mapper #3
		MAP_AXROM = 5'd8, // Mapper #7
		MAP_MMC3 = 5'd20 // Mapper #4
	} mapper_e;

	// Outer register index from the low address bits of $5xxx
	typedef enum logic [2:0]
	{
		CFG_BASE_HI = 3'd0, // $5xx0, base A26-A22
		CFG_BASE_LO = 3'd1, // $5xx1, base A21-A14
		CFG_PRG_MASK = 3'd2, // $5xx2
		CFG_CHR_BANK = 3'd3, // $5xx3, also CNROM bank
		CFG_CHR_MASK = 3'd4, // $5xx4
		CFG_SRAM_PAGE = 3'd5, // $5xx5, page and PRG bank
		CFG_MAPPER = 3'd6, // $5xx6
		CFG_CONTROL = 3'd7 // $5xx7, lockout and enables
	} cfg_reg_e;

	// Nametable arrangement for CIRAM A10
	typedef enum logic [1:0]
	{
		MIR_VERTICAL = 2'd0, // A10 from PPU A10
		MIR_HORIZONTAL = 2'd1, // A10 from PPU A11
		MIR_SINGLE_A = 2'd2, // Always page 0
		MIR_SINGLE_B = 2'd3 // Always page 1
	} mirror_e;

endpackage
